//--- ffe_top.f
+incdir+rtl
rtl/ffe_pkg.sv
rtl/ffe_weight_bank.sv
rtl/ffe_code_history.sv
rtl/ffe_lane_mac.sv
rtl/ffe_top.sv
tb/tb_ffe.sv

//--- rtl/ffe_code_history.sv
`timescale 1ns/1ps
`include "ffe_defs.svh"

module ffe_code_history
   import ffe_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  code_word_t   codes,
   input  logic         in_valid,
   output code_window_t window,
   output logic         win_valid
);

   localparam int hist_len = `FFE_LENGTH - 1;

   // oldest first, entries 0..hist_len-1 are history, the rest the current word
   code_window_t window_q;
   logic         valid_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         window_q <= '0;
      end else if (in_valid) begin
         // newest hist_len codes of the old window become the history
         for (int i = 0; i < hist_len; i++) begin
            window_q[i] <= window_q[i + `FFE_WIDTH];
         end
         for (int j = 0; j < `FFE_WIDTH; j++) begin
            window_q[hist_len + j] <= codes[j];
         end
      end
   end

   // gaps leave the stream untouched
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= in_valid;
      end
   end

   assign window    = window_q;
   assign win_valid = valid_q;

endmodule

//--- rtl/ffe_defs.svh
`ifndef FFE_DEFS_SVH
`define FFE_DEFS_SVH

// lanes per input word, lane 0 is the oldest sample
`define FFE_WIDTH 4

// taps per lane
`define FFE_LENGTH 6

// signed sample code from the slicer/adc
`define FFE_CODE_BITS 8

// signed tap weight
`define FFE_WEIGHT_BITS 10

// saturated output width
`define FFE_RESULT_BITS 16

// full precision code times weight
`define FFE_PROD_BITS (`FFE_CODE_BITS + `FFE_WEIGHT_BITS)

// growth for summing FFE_LENGTH products
`define FFE_SUM_BITS (`FFE_PROD_BITS + $clog2(`FFE_LENGTH))

// codes visible to the lanes in one cycle
`define FFE_WINDOW_LEN (`FFE_WIDTH + `FFE_LENGTH - 1)

// index fields of a weight command
`define FFE_LANE_IDX_BITS $clog2(`FFE_WIDTH)
`define FFE_TAP_IDX_BITS $clog2(`FFE_LENGTH)

`endif

//--- rtl/ffe_lane_mac.sv
`timescale 1ns/1ps
`include "ffe_defs.svh"

module ffe_lane_mac
   import ffe_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  lane_codes_t   taps,
   input  lane_weights_t weights,
   input  logic          in_valid,
   output result_t       result,
   output logic          out_valid
);

   localparam int sum_bits = `FFE_SUM_BITS;
   localparam int res_bits = `FFE_RESULT_BITS;

   // result range expressed at sum width
   localparam logic signed [sum_bits-1:0] sat_max =
      {{(sum_bits - res_bits + 1){1'b0}}, {(res_bits - 1){1'b1}}};
   localparam logic signed [sum_bits-1:0] sat_min =
      {{(sum_bits - res_bits + 1){1'b1}}, {(res_bits - 1){1'b0}}};

   lane_codes_t                      taps_q;
   logic signed [`FFE_PROD_BITS-1:0] prod_q [`FFE_LENGTH];
   logic signed [sum_bits-1:0]       tree_sum;
   logic signed [sum_bits-1:0]       sum_q;
   result_t                          result_q;
   logic                             valid0_q;
   logic                             valid1_q;
   logic                             valid2_q;
   logic                             valid3_q;

   // window slice held for the multipliers
   always_ff @(posedge clk) begin
      if (in_valid) begin
         taps_q <= taps;
      end
   end

   // stage 1, one multiplier per tap, weights as active at this edge
   always_ff @(posedge clk) begin
      if (valid0_q) begin
         for (int k = 0; k < `FFE_LENGTH; k++) begin
            prod_q[k] <= $signed(taps_q[k]) * $signed(weights[k]);
         end
      end
   end

   // products sign extended before the add
   always_comb begin
      tree_sum = '0;
      for (int k = 0; k < `FFE_LENGTH; k++) begin
         tree_sum = tree_sum + sum_bits'(prod_q[k]);
      end
   end

   // stage 2
   always_ff @(posedge clk) begin
      if (valid1_q) begin
         sum_q <= tree_sum;
      end
   end

   // stage 3, clamp to the result range
   always_ff @(posedge clk) begin
      if (reset) begin
         result_q <= '0;
      end else if (valid2_q) begin
         if (sum_q > sat_max) begin
            result_q <= sat_max[res_bits-1:0];
         end else if (sum_q < sat_min) begin
            result_q <= sat_min[res_bits-1:0];
         end else begin
            result_q <= sum_q[res_bits-1:0];
         end
      end
   end

   // valid runs beside the data
   always_ff @(posedge clk) begin
      if (reset) begin
         valid0_q <= 1'b0;
         valid1_q <= 1'b0;
         valid2_q <= 1'b0;
         valid3_q <= 1'b0;
      end else begin
         valid0_q <= in_valid;
         valid1_q <= valid0_q;
         valid2_q <= valid1_q;
         valid3_q <= valid2_q;
      end
   end

   assign result    = result_q;
   assign out_valid = valid3_q;

endmodule

//--- rtl/ffe_pkg.sv
`include "ffe_defs.svh"

package ffe_pkg;

   // weight command opcode
   typedef enum logic [1:0] {
      WT_IDLE   = 2'd0,
      WT_WRITE  = 2'd1,
      WT_COMMIT = 2'd2
   } wt_cmd_e;

   typedef logic signed [`FFE_CODE_BITS-1:0]   code_t;
   typedef logic signed [`FFE_WEIGHT_BITS-1:0] weight_t;
   typedef logic signed [`FFE_RESULT_BITS-1:0] result_t;

   // one tap write or a commit of the whole shadow bank
   typedef struct packed {
      wt_cmd_e                       cmd;
      logic [`FFE_LANE_IDX_BITS-1:0] lane;
      logic [`FFE_TAP_IDX_BITS-1:0]  tap;
      weight_t                       value;
   } wt_write_t;

   // input word, index 0 is the oldest code
   typedef code_t [`FFE_WIDTH-1:0] code_word_t;

   // history plus current word, index 0 is the oldest code
   typedef code_t [`FFE_WINDOW_LEN-1:0] code_window_t;

   // codes seen by one lane, index k is k positions back
   typedef code_t [`FFE_LENGTH-1:0] lane_codes_t;

   typedef weight_t [`FFE_LENGTH-1:0] lane_weights_t;

   typedef lane_weights_t [`FFE_WIDTH-1:0] weight_set_t;

   typedef result_t [`FFE_WIDTH-1:0] result_word_t;

endpackage

//--- rtl/ffe_top.sv
`timescale 1ns/1ps
`include "ffe_defs.svh"

module ffe_top
   import ffe_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  wt_write_t    wt,
   input  code_word_t   codes,
   input  logic         in_valid,
   output result_word_t results,
   output logic         out_valid
);

   weight_set_t            active;
   code_window_t           window;
   logic                   win_valid;
   lane_codes_t            lane_taps  [`FFE_WIDTH];
   logic [`FFE_WIDTH-1:0]  lane_valid;

   ffe_weight_bank ffe_weight_bank_i (
      .clk    (clk),
      .reset  (reset),
      .wt     (wt),
      .active (active)
   );

   ffe_code_history ffe_code_history_i (
      .clk       (clk),
      .reset     (reset),
      .codes     (codes),
      .in_valid  (in_valid),
      .window    (window),
      .win_valid (win_valid)
   );

   for (genvar j = 0; j < `FFE_WIDTH; j++) begin : g_lane

      // lane j's own code sits at window[j+FFE_LENGTH-1], tap k looks k back
      for (genvar k = 0; k < `FFE_LENGTH; k++) begin : g_tap
         assign lane_taps[j][k] = window[j + `FFE_LENGTH - 1 - k];
      end

      ffe_lane_mac ffe_lane_mac_i (
         .clk       (clk),
         .reset     (reset),
         .taps      (lane_taps[j]),
         .weights   (active[j]),
         .in_valid  (win_valid),
         .result    (results[j]),
         .out_valid (lane_valid[j])
      );

   end

   // all lanes run in lockstep
   assign out_valid = lane_valid[0];

endmodule

//--- rtl/ffe_weight_bank.sv
`timescale 1ns/1ps
`include "ffe_defs.svh"

module ffe_weight_bank
   import ffe_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  wt_write_t   wt,
   output weight_set_t active
);

   weight_set_t shadow_q;
   weight_set_t active_q;
   logic        tap_ok;

   // tap field is wider than the tap count
   assign tap_ok = (wt.tap < `FFE_LENGTH);

   // shadow collects single tap writes
   always_ff @(posedge clk) begin
      if (reset) begin
         shadow_q <= '0;
      end else begin
         if (wt.cmd == WT_WRITE && tap_ok) begin
            shadow_q[wt.lane][wt.tap] <= wt.value;
         end
      end
   end

   // whole set goes live on one edge so a lane never mixes old and new taps
   always_ff @(posedge clk) begin
      if (reset) begin
         active_q <= '0;
      end else begin
         case (wt.cmd)
            WT_COMMIT: begin
               active_q <= shadow_q;
            end
            default: begin
               active_q <= active_q;
            end
         endcase
      end
   end

   assign active = active_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# builds tb_ffe with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert \
   -f ffe_top.f \
   --top-module tb_ffe \
   -o tb_ffe_sim > build.log 2>&1 \
   && ./obj_dir/tb_ffe_sim > sim.log 2>&1 \
   || { echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -q "Done: errors found" sim.log \
   && { echo "simulation FAILED"; exit 1; } \
   || { echo "simulation passed"; exit 0; }

//--- tb/tb_ffe.sv
`timescale 1ns/1ps
`include "ffe_defs.svh"

module tb_ffe
   import ffe_pkg::*;
;

   localparam int res_max = (1 << (`FFE_RESULT_BITS - 1)) - 1;
   localparam int res_min = -(1 << (`FFE_RESULT_BITS - 1));

   logic         clk;
   logic         reset;
   wt_write_t    wt;
   code_word_t   codes;
   logic         in_valid;
   result_word_t results;
   logic         out_valid;

   logic [31:0]  rng = 32'h7aa4d954;
   int           cyc = 0;
   int           errors = 0;
   int           checked = 0;

   // reference model state
   int           shadow_m [`FFE_WIDTH][`FFE_LENGTH];
   int           active_m [`FFE_WIDTH][`FFE_LENGTH];
   int           stream [$];
   int           word_v [`FFE_WIDTH];
   result_word_t exp_q [$];
   int           exp_cyc_q [$];
   result_word_t exp_w;
   int           exp_c;

   ffe_top ffe_top_i (
      .clk       (clk),
      .reset     (reset),
      .wt        (wt),
      .codes     (codes),
      .in_valid  (in_valid),
      .results   (results),
      .out_valid (out_valid)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic int rand_code();
      logic [31:0]       r;
      logic signed [7:0] c;
      r = next_rand();
      c = r[7:0];
      return int'(c);
   endfunction

   // small weights so only some sums clip
   function automatic int rand_weight();
      logic [31:0]       r;
      logic signed [9:0] w;
      r = next_rand();
      w = r[9:0];
      return int'(w) >>> 3;
   endfunction

   function automatic int saturate(input int s);
      if (s > res_max) return res_max;
      if (s < res_min) return res_min;
      return s;
   endfunction

   // tap k of lane sees the code k positions back in the stream
   function automatic int lane_sum(input int pos, input int lane);
      int s;
      int p;
      s = 0;
      for (int k = 0; k < `FFE_LENGTH; k++) begin
         p = pos - k;
         if (p >= 0) s += active_m[lane][k] * stream[p];
      end
      return s;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic idle(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic write_tap(input int lane, input int tap, input int val);
      wt.cmd   = WT_WRITE;
      wt.lane  = lane[`FFE_LANE_IDX_BITS-1:0];
      wt.tap   = tap[`FFE_TAP_IDX_BITS-1:0];
      wt.value = val[`FFE_WEIGHT_BITS-1:0];
      next_cycle();
      wt.cmd = WT_IDLE;
      shadow_m[lane][tap] = val;
   endtask

   task automatic commit();
      wt.cmd = WT_COMMIT;
      next_cycle();
      wt.cmd = WT_IDLE;
      active_m = shadow_m;
   endtask

   task automatic send_word();
      result_word_t e;
      int           base;
      in_valid = 1'b1;
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         codes[j] = code_t'(word_v[j]);
         stream.push_back(word_v[j]);
      end
      base = stream.size() - `FFE_WIDTH;
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         e[j] = result_t'(saturate(lane_sum(base + j, j)));
      end
      exp_q.push_back(e);
      // sampled at the next edge, result 4 edges later
      exp_cyc_q.push_back(cyc + 5);
      next_cycle();
      in_valid = 1'b0;
   endtask

   task automatic send_fill(input int v);
      for (int j = 0; j < `FFE_WIDTH; j++) word_v[j] = v;
      send_word();
   endtask

   task automatic send_random(input int n, input bit gaps);
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         for (int j = 0; j < `FFE_WIDTH; j++) word_v[j] = rand_code();
         send_word();
         r = next_rand();
         if (gaps) idle(int'(r[1:0]) % 3);
      end
   endtask

   task automatic drain();
      int t;
      int quiet;
      t = 0;
      while (exp_q.size() > 0 && t < 100) begin
         next_cycle();
         t++;
      end
      if (exp_q.size() > 0) begin
         $display("timeout: %0d result words never came out", exp_q.size());
         errors++;
         exp_q.delete();
         exp_cyc_q.delete();
      end
      quiet = 0;
      t = 0;
      while (quiet < 5 && t < 100) begin
         next_cycle();
         t++;
         if (out_valid) quiet = 0;
         else quiet++;
      end
      if (quiet < 5) begin
         $display("timeout: out_valid did not stay low for 5 cycles");
         errors++;
      end
   endtask

   // output side, sampled mid cycle
   always @(negedge clk) begin
      if (!reset && out_valid) begin
         assert (exp_q.size() > 0) else begin
            $display("out_valid pulse at cycle %0d with no word in flight", cyc);
            errors++;
         end
         if (exp_q.size() > 0) begin
            exp_w = exp_q.pop_front();
            exp_c = exp_cyc_q.pop_front();
            checked++;
            assert (exp_c == cyc) else begin
               $display("result word due at cycle %0d came at cycle %0d", exp_c, cyc);
               errors++;
            end
            for (int j = 0; j < `FFE_WIDTH; j++) begin
               assert (results[j] == exp_w[j]) else begin
                  $display("** Error results[%0d]: expected %h, got %h", j, exp_w[j], results[j]);
                  errors++;
               end
            end
         end
      end else if (!reset && exp_cyc_q.size() > 0) begin
         assert (exp_cyc_q[0] != cyc) else begin
            $display("out_valid missing at cycle %0d", cyc);
            errors++;
         end
      end
   end

   initial begin
      #2_000_000;
      $display("simulation ran past its time limit");
      $display("Done: errors found");
      $finish;
   end

   initial begin
      reset    = 1'b1;
      wt       = '0;
      wt.cmd   = WT_IDLE;
      codes    = '0;
      in_valid = 1'b0;
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         for (int k = 0; k < `FFE_LENGTH; k++) begin
            shadow_m[j][k] = 0;
            active_m[j][k] = 0;
         end
      end
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      // quiet after reset
      for (int i = 0; i < 8; i++) begin
         next_cycle();
         assert (out_valid == 1'b0) else begin
            $display("** Error out_valid: expected 0, got %h", out_valid);
            errors++;
         end
         assert (results == '0) else begin
            $display("** Error results: expected 0, got %h", results);
            errors++;
         end
      end

      // impulse, distinct signed taps per lane
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         for (int k = 0; k < `FFE_LENGTH; k++) begin
            write_tap(j, k, (k % 2 == 1) ? -(j * 8 + k + 1) : (j * 8 + k + 1));
         end
      end
      commit();
      send_fill(0);
      send_fill(0);
      // one impulse per lane position so every tap of every lane shows up
      for (int p = 0; p < `FFE_WIDTH; p++) begin
         for (int j = 0; j < `FFE_WIDTH; j++) begin
            word_v[j] = (j == p) ? 1 : 0;
         end
         send_word();
         send_fill(0);
         send_fill(0);
      end
      drain();

      // random stream with gaps
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         for (int k = 0; k < `FFE_LENGTH; k++) write_tap(j, k, rand_weight());
      end
      commit();
      send_random(60, 1'b1);
      drain();

      // extremes, odd lanes use the most negative weight
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         for (int k = 0; k < `FFE_LENGTH; k++) write_tap(j, k, (j % 2 == 1) ? -512 : 511);
      end
      commit();
      repeat (3) send_fill(127);
      repeat (3) send_fill(-128);
      send_fill(127);
      drain();

      // shadow writes stay invisible until commit
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         for (int k = 0; k < `FFE_LENGTH; k++) write_tap(j, k, rand_weight());
      end
      commit();
      send_random(8, 1'b0);
      drain();
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         for (int k = 0; k < `FFE_LENGTH; k++) write_tap(j, k, rand_weight());
      end
      send_random(8, 1'b1);
      drain();
      commit();
      send_random(8, 1'b1);
      drain();

      $display("errors: %0d, result words checked: %0d", errors, checked);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
